// File: Makefile
VERILATOR ?= verilator
TOP       ?= sdram_controller_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG) || ! grep -q "Testbench passed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/refresh_timer.sv
// Counts consecutive idle cycles and flags when an auto refresh is due
module refresh_timer import sdram_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    sdram_ctrl_if.timer ctrl
);

    logic [REFRESH_CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= REFRESH_CNT_W'(REFRESH_INTERVAL);
        end else if (ctrl.state != ST_IDLE) begin
            count <= REFRESH_CNT_W'(REFRESH_INTERVAL);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign ctrl.refresh_due = (count == '0);

endmodule

// File: rtl/sdram_cmd_gen.sv
// Decodes the controller state into SDRAM command pins, bank, address and byte mask
module sdram_cmd_gen import sdram_pkg::*; (
    sdram_ctrl_if.cmd          ctrl,
    output logic               dram_ras_n,
    output logic               dram_cas_n,
    output logic               dram_we_n,
    output logic [BANK_W-1:0]  dram_ba,
    output logic [ROW_W-1:0]   dram_addr,
    output logic               dram_dqm
);

    sdram_cmd_e  dram_cmd;
    sdram_addr_u addr_u;

    always_comb begin
        dram_cmd = CMD_NOP;
        dram_ba = '0;
        addr_u = '0;
        case (ctrl.state)
            ST_INIT_PRECHARGE: begin
                dram_cmd = CMD_PRECHARGE;
                addr_u.col_cmd.a10 = 1'b1;
            end
            ST_INIT_REF0, ST_INIT_REF1, ST_REF_AUTO: begin
                dram_cmd = CMD_REFRESH;
            end
            ST_INIT_LOAD: begin
                dram_cmd = CMD_LOAD_MODE;
                addr_u.mode = MODE_WORD;
            end
            ST_RD_ACTIVE, ST_WR_ACTIVE: begin
                dram_cmd = CMD_ACTIVE;
                dram_ba = ctrl.req_addr.bank;
                addr_u.row = ctrl.req_addr.row;
            end
            ST_RD_CMD, ST_WR_CMD: begin
                dram_cmd = (ctrl.state == ST_RD_CMD) ? CMD_READ : CMD_WRITE;
                dram_ba = ctrl.req_addr.bank;
                // Auto precharge closes the row after the access
                addr_u.col_cmd.a10 = 1'b1;
                addr_u.col_cmd.col = ctrl.req_addr.col;
            end
            default: begin
                dram_cmd = CMD_NOP;
            end
        endcase
    end

    assign {dram_ras_n, dram_cas_n, dram_we_n} = dram_cmd;
    assign dram_addr = addr_u;

    assign dram_dqm = !(ctrl.state inside {ST_RD_NOP, ST_RD_ACTIVE, ST_RD_CMD, ST_RD_WAIT,
        ST_RD_DATA, ST_WR_NOP, ST_WR_ACTIVE, ST_WR_CMD, ST_WR_WAIT});

endmodule

// File: rtl/sdram_controller.sv
// Single-port SDRAM controller top level; connects host strobes to the SDRAM pins
module sdram_controller import sdram_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              ready,
    input  host_op_e          cmd,
    input  host_addr_t        addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic [DATA_W-1:0] dram_dq_in,
    output logic [DATA_W-1:0] rd_data,
    output logic              valid,
    output logic              dram_ras_n,
    output logic              dram_cas_n,
    output logic              dram_we_n,
    output logic [BANK_W-1:0] dram_ba,
    output logic [ROW_W-1:0]  dram_addr,
    output logic              dram_dqm,
    output logic [DATA_W-1:0] dram_dq_out,
    output logic              dram_dq_oe
);

    sdram_ctrl_if ctrl ();

    sdram_fsm u_fsm (
        .clk   (clk),
        .rst   (rst),
        .ready (ready),
        .cmd   (cmd),
        .valid (valid),
        .ctrl  (ctrl.fsm)
    );

    refresh_timer u_refresh_timer (
        .clk  (clk),
        .rst  (rst),
        .ctrl (ctrl.timer)
    );

    sdram_cmd_gen u_cmd_gen (
        .ctrl       (ctrl.cmd),
        .dram_ras_n (dram_ras_n),
        .dram_cas_n (dram_cas_n),
        .dram_we_n  (dram_we_n),
        .dram_ba    (dram_ba),
        .dram_addr  (dram_addr),
        .dram_dqm   (dram_dqm)
    );

    sdram_data_path u_data_path (
        .clk         (clk),
        .rst         (rst),
        .addr        (addr),
        .wr_data     (wr_data),
        .dram_dq_in  (dram_dq_in),
        .rd_data     (rd_data),
        .dram_dq_out (dram_dq_out),
        .dram_dq_oe  (dram_dq_oe),
        .ctrl        (ctrl.data)
    );

endmodule

// File: rtl/sdram_ctrl_if.sv
// Control signals shared between the FSM, refresh timer, command generator and data path
interface sdram_ctrl_if import sdram_pkg::*; ();

    ctrl_state_e state;
    logic        accept;
    logic        refresh_due;
    host_addr_t  req_addr;

    modport fsm (output state, output accept, input refresh_due);

    modport timer (input state, output refresh_due);

    modport cmd (input state, input req_addr);

    modport data (input state, input accept, output req_addr);

endinterface

// File: rtl/sdram_data_path.sv
// Captures host requests, drives write data to the SDRAM and latches read data
module sdram_data_path import sdram_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  host_addr_t        addr,
    input  logic [DATA_W-1:0] wr_data,
    input  logic [DATA_W-1:0] dram_dq_in,
    output logic [DATA_W-1:0] rd_data,
    output logic [DATA_W-1:0] dram_dq_out,
    output logic              dram_dq_oe,
    sdram_ctrl_if.data        ctrl
);

    host_addr_t        req_addr_q;
    logic [DATA_W-1:0] wr_word;

    always_ff @(posedge clk) begin
        if (ctrl.accept) begin
            req_addr_q <= addr;
            wr_word <= wr_data;
        end
        // Data arrives CAS_LATENCY cycles after the READ command
        if (ctrl.state == ST_RD_DATA) begin
            rd_data <= dram_dq_in;
        end
    end

    // Registered enable lines up with the WRITE command cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            dram_dq_oe <= 1'b0;
        end else begin
            dram_dq_oe <= (ctrl.state == ST_WR_ACTIVE);
        end
    end

    assign dram_dq_out = wr_word;
    assign ctrl.req_addr = req_addr_q;

endmodule

// File: rtl/sdram_fsm.sv
// Controller sequencer for power-up, read, write and refresh, with the host valid pulse
module sdram_fsm import sdram_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         ready,
    input  host_op_e     cmd,
    output logic         valid,
    sdram_ctrl_if.fsm    ctrl
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        req_read;
    logic        req_write;

    assign req_read = ready && (cmd == OP_READ);
    assign req_write = ready && (cmd == OP_WRITE);

    // Requests are only taken from idle
    assign ctrl.accept = (state_q == ST_IDLE) && (req_read || req_write);
    assign ctrl.state = state_q;

    always_comb begin
        case (state_q)
            ST_RESET:          state_d = ST_INIT_NOP0;
            ST_INIT_NOP0:      state_d = ST_INIT_PRECHARGE;
            ST_INIT_PRECHARGE: state_d = ST_INIT_REF0;
            ST_INIT_REF0:      state_d = ST_INIT_NOP1;
            ST_INIT_NOP1:      state_d = ST_INIT_REF1;
            ST_INIT_REF1:      state_d = ST_INIT_NOP2;
            ST_INIT_NOP2:      state_d = ST_INIT_LOAD;
            ST_INIT_LOAD:      state_d = ST_INIT_NOP3;
            ST_INIT_NOP3:      state_d = ST_IDLE;

            ST_RD_NOP:         state_d = ST_RD_ACTIVE;
            ST_RD_ACTIVE:      state_d = ST_RD_CMD;
            ST_RD_CMD:         state_d = ST_RD_WAIT;
            ST_RD_WAIT:        state_d = ST_RD_DATA;
            ST_RD_DATA:        state_d = ST_IDLE;

            ST_WR_NOP:         state_d = ST_WR_ACTIVE;
            ST_WR_ACTIVE:      state_d = ST_WR_CMD;
            ST_WR_CMD:         state_d = ST_WR_WAIT;
            ST_WR_WAIT:        state_d = ST_IDLE;

            ST_REF_NOP0:       state_d = ST_REF_AUTO;
            ST_REF_AUTO:       state_d = ST_REF_NOP1;
            ST_REF_NOP1:       state_d = ST_REF_NOP2;
            ST_REF_NOP2:       state_d = ST_REF_NOP3;
            ST_REF_NOP3:       state_d = ST_IDLE;

            // Host request beats a due refresh
            ST_IDLE: begin
                if (req_read) begin
                    state_d = ST_RD_NOP;
                end else if (req_write) begin
                    state_d = ST_WR_NOP;
                end else if (ctrl.refresh_due) begin
                    state_d = ST_REF_NOP0;
                end else begin
                    state_d = ST_IDLE;
                end
            end

            default:           state_d = ST_RESET;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ST_RESET;
            valid <= 1'b0;
        end else begin
            state_q <= state_d;
            // One cycle after the last state of each sequence
            valid <= (state_q == ST_INIT_NOP3) || (state_q == ST_RD_DATA)
                || (state_q == ST_WR_WAIT);
        end
    end

endmodule

// File: rtl/sdram_pkg.sv
// Shared widths, timing constants and types for the SDRAM controller; imported by every RTL file
package sdram_pkg;

    localparam int DATA_W = 16;
    localparam int BANK_W = 2;
    localparam int ROW_W = 13;
    localparam int COL_W = 10;
    localparam int HOST_ADDR_W = BANK_W + ROW_W + COL_W;

    localparam int REFRESH_INTERVAL = 32;
    localparam int REFRESH_CNT_W = $clog2(REFRESH_INTERVAL + 1);
    localparam int CAS_LATENCY = 2;

    typedef enum logic [1:0] {
        OP_NONE  = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b10
    } host_op_e;

    typedef struct packed {
        logic [BANK_W-1:0] bank;
        logic [ROW_W-1:0]  row;
        logic [COL_W-1:0]  col;
    } host_addr_t;

    // {RAS_N, CAS_N, WE_N}
    typedef enum logic [2:0] {
        CMD_NOP       = 3'b111,
        CMD_ACTIVE    = 3'b011,
        CMD_READ      = 3'b101,
        CMD_WRITE     = 3'b100,
        CMD_PRECHARGE = 3'b010,
        CMD_REFRESH   = 3'b001,
        CMD_LOAD_MODE = 3'b000
    } sdram_cmd_e;

    typedef enum logic [23:0] {
        ST_RESET          = 24'h000001,
        ST_INIT_NOP0      = 24'h000002,
        ST_INIT_PRECHARGE = 24'h000004,
        ST_INIT_REF0      = 24'h000008,
        ST_INIT_NOP1      = 24'h000010,
        ST_INIT_REF1      = 24'h000020,
        ST_INIT_NOP2      = 24'h000040,
        ST_INIT_LOAD      = 24'h000080,
        ST_INIT_NOP3      = 24'h000100,
        ST_RD_NOP         = 24'h000200,
        ST_RD_ACTIVE      = 24'h000400,
        ST_RD_CMD         = 24'h000800,
        ST_RD_WAIT        = 24'h001000,
        ST_RD_DATA        = 24'h002000,
        ST_WR_NOP         = 24'h004000,
        ST_WR_ACTIVE      = 24'h008000,
        ST_WR_CMD         = 24'h010000,
        ST_WR_WAIT        = 24'h020000,
        ST_REF_NOP0       = 24'h040000,
        ST_REF_AUTO       = 24'h080000,
        ST_REF_NOP1       = 24'h100000,
        ST_REF_NOP2       = 24'h200000,
        ST_REF_NOP3       = 24'h400000,
        ST_IDLE           = 24'h800000
    } ctrl_state_e;

    typedef struct packed {
        logic [1:0]       unused;
        logic             a10;
        logic [COL_W-1:0] col;
    } sdram_col_cmd_t;

    typedef struct packed {
        logic [2:0] reserved;
        logic       write_burst;
        logic [1:0] op_mode;
        logic [2:0] cas_latency;
        logic       burst_type;
        logic [2:0] burst_len;
    } sdram_mode_t;

    // One address bus, read three ways depending on the command
    typedef union packed {
        logic [ROW_W-1:0] row;
        sdram_col_cmd_t   col_cmd;
        sdram_mode_t      mode;
    } sdram_addr_u;

    // Burst of 1, interleaved, single-location writes
    localparam sdram_mode_t MODE_WORD = '{
        reserved:    3'b000,
        write_burst: 1'b1,
        op_mode:     2'b00,
        cas_latency: 3'(CAS_LATENCY),
        burst_type:  1'b1,
        burst_len:   3'b000
    };

endpackage

// File: verification/sdram_controller_asserts.sv
// Pin protocol assertions, bound into the SDRAM controller top level
module sdram_controller_asserts import sdram_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              valid,
    input logic              dram_ras_n,
    input logic              dram_cas_n,
    input logic              dram_we_n,
    input logic [BANK_W-1:0] dram_ba,
    input logic [ROW_W-1:0]  dram_addr,
    input logic              dram_dq_oe
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [2:0] pins;
    logic [3:0] bank_open;

    assign pins = {dram_ras_n, dram_cas_n, dram_we_n};

    // Open rows per bank; the controller only precharges all banks
    always_ff @(posedge clk) begin
        if (rst) begin
            bank_open <= '0;
        end else if (pins == CMD_PRECHARGE || pins == CMD_REFRESH) begin
            bank_open <= '0;
        end else if (pins == CMD_ACTIVE) begin
            bank_open[dram_ba] <= 1'b1;
        end else if ((pins == CMD_READ || pins == CMD_WRITE) && dram_addr[COL_W]) begin
            bank_open[dram_ba] <= 1'b0;
        end
    end

    oe_only_with_write: assert property (@(posedge clk) disable iff (rst)
        dram_dq_oe |-> pins == CMD_WRITE)
        else $error("write data driven without a WRITE command");

    valid_single_cycle: assert property (@(posedge clk) disable iff (rst)
        valid |=> !valid)
        else $error("valid held high for two cycles");

    access_needs_active: assert property (@(posedge clk) disable iff (rst)
        (pins == CMD_READ || pins == CMD_WRITE) |-> bank_open[dram_ba])
        else $error("READ or WRITE issued to a bank with no open row");

endmodule

bind sdram_controller sdram_controller_asserts u_asserts (.*);

// File: verification/sdram_controller_tb.sv
// Testbench for the SDRAM controller; random host traffic against a pin-level SDRAM model
module sdram_controller_tb import sdram_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REQ = 60;
    localparam int TIMEOUT = 40;
    // Burst 1, interleaved, CL2, single-location write
    localparam logic [ROW_W-1:0] MODE_EXP = 13'b000_1_00_010_1_000;

    logic              clk;
    logic              rst;
    logic              ready;
    host_op_e          cmd;
    host_addr_t        addr;
    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] dram_dq_in = '0;
    logic [DATA_W-1:0] rd_data;
    logic [DATA_W-1:0] dram_dq_out;
    logic              valid;
    logic              dram_ras_n;
    logic              dram_cas_n;
    logic              dram_we_n;
    logic [BANK_W-1:0] dram_ba;
    logic [ROW_W-1:0]  dram_addr;
    logic              dram_dqm;
    logic              dram_dq_oe;

    // Memory as seen through the pins, and the host-side scoreboard
    logic [DATA_W-1:0] mem [logic [HOST_ADDR_W-1:0]];
    logic [DATA_W-1:0] model [logic [HOST_ADDR_W-1:0]];
    logic [ROW_W-1:0]  open_row [4];
    host_addr_t        exp_addr;
    logic [DATA_W-1:0] rd_word;
    int rd_delay = 0;
    int n_active = 0;
    int n_rw = 0;
    int n_refresh = 0;
    int n_valid = 0;
    int n_req = 0;

    tb_clock_gen clock_gen (.clk(clk));

    sdram_controller uut (.*);

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            report_failure("value check failed");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    // One request; poke strobes ready again while the controller is busy
    task automatic do_request(input host_op_e op, input host_addr_t a,
                              input logic [DATA_W-1:0] d, input bit poke);
        int n;
        logic [DATA_W-1:0] expected;
        expected = model.exists(a) ? model[a] : '0;
        exp_addr = a;
        ready = 1'b1;
        cmd = op;
        addr = a;
        wr_data = d;
        n = 0;
        @(posedge clk);
        #2;
        ready = 1'b0;
        cmd = OP_NONE;
        addr = HOST_ADDR_W'($urandom);
        wr_data = DATA_W'($urandom);
        do begin
            if (n == TIMEOUT) begin
                report_failure("timed out waiting for valid after a request");
            end
            @(posedge clk);
            #2;
            n++;
            ready = poke && (n == 1);
            cmd = ready ? OP_WRITE : OP_NONE;
        end while (!valid);
        if (op == OP_READ) begin
            check_equal("read latency", 32'(5), 32'(n));
            check_equal("read data", 32'(expected), 32'(rd_data));
        end else begin
            check_equal("write latency", 32'(4), 32'(n));
            model[a] = d;
        end
        n_req++;
    endtask

    // SDRAM model sampled and driven 2 ns after each rising edge
    always begin
        logic [2:0] pins;
        logic [HOST_ADDR_W-1:0] key;
        @(posedge clk);
        #2;
        pins = {dram_ras_n, dram_cas_n, dram_we_n};
        key = {dram_ba, open_row[dram_ba], dram_addr[COL_W-1:0]};
        dram_dq_in = '0;
        if (rd_delay > 0) begin
            rd_delay = rd_delay - 1;
            if (rd_delay == 0) begin
                dram_dq_in = rd_word;
            end
        end
        if (valid) begin
            n_valid++;
        end
        case (pins)
            CMD_ACTIVE: begin
                open_row[dram_ba] = dram_addr;
                n_active++;
                check_equal("active bank", 32'(exp_addr.bank), 32'(dram_ba));
                check_equal("active row", 32'(exp_addr.row), 32'(dram_addr));
            end
            CMD_READ, CMD_WRITE: begin
                n_rw++;
                check_equal("access bank", 32'(exp_addr.bank), 32'(dram_ba));
                check_equal("access column", 32'({1'b1, exp_addr.col}),
                            32'(dram_addr[COL_W:0]));
                check_equal("access dqm", 32'(0), 32'(dram_dqm));
                if (pins == CMD_WRITE) begin
                    check_equal("write enable", 32'(1), 32'(dram_dq_oe));
                    mem[key] = dram_dq_out;
                end else begin
                    rd_word = mem.exists(key) ? mem[key] : '0;
                    rd_delay = CAS_LATENCY;
                end
            end
            CMD_REFRESH: n_refresh++;
            default: ;
        endcase
    end

    initial begin
        sdram_cmd_e init_seq [9];
        host_addr_t pool [8];
        host_op_e   op;
        int ref_before;
        int valid_before;
        init_seq = '{CMD_NOP, CMD_PRECHARGE, CMD_REFRESH, CMD_NOP, CMD_REFRESH, CMD_NOP,
            CMD_LOAD_MODE, CMD_NOP, CMD_NOP};
        rst = 1'b1;
        ready = 1'b0;
        cmd = OP_NONE;
        addr = '0;
        wr_data = '0;
        void'($urandom(91908));
        for (int i = 0; i < 8; i++) begin
            pool[i] = HOST_ADDR_W'($urandom);
        end
        idle_cycles(16);
        rst = 1'b0;

        // Power-up sequence, one command per cycle
        for (int k = 1; k <= 9; k++) begin
            @(posedge clk);
            #2;
            check_equal("init command", 32'(init_seq[k-1]),
                        32'({dram_ras_n, dram_cas_n, dram_we_n}));
            check_equal("init dqm", 32'(1), 32'(dram_dqm));
            check_equal("init valid", 32'(k == 9), 32'(valid));
            if (k == 2) begin
                check_equal("precharge all", 32'(1), 32'(dram_addr[COL_W]));
            end
            if (k == 7) begin
                check_equal("mode word", 32'(MODE_EXP), 32'(dram_addr));
            end
        end

        do_request(OP_READ, pool[0], '0, 1'b0);
        for (int i = 0; i < NUM_REQ; i++) begin
            op = ($urandom_range(1) == 1) ? OP_WRITE : OP_READ;
            do_request(op, pool[$urandom_range(7)], DATA_W'($urandom),
                       $urandom_range(3) == 0);
            idle_cycles($urandom_range(3));
        end

        // Known word stored before the refresh so the read after it has data to return
        do_request(OP_WRITE, pool[1], DATA_W'($urandom), 1'b0);

        // Long idle stretch triggers exactly one refresh
        idle_cycles(1);
        ref_before = n_refresh;
        valid_before = n_valid;
        idle_cycles(44);
        check_equal("refresh count", 32'(1), 32'(n_refresh - ref_before));
        check_equal("refresh valid", 32'(valid_before), 32'(n_valid));
        do_request(OP_READ, pool[1], '0, 1'b0);
        do_request(OP_READ, pool[2], '0, 1'b0);

        idle_cycles(2);
        check_equal("active count", 32'(n_req), 32'(n_active));
        check_equal("access count", 32'(n_req), 32'(n_rw));
        check_equal("valid count", 32'(n_req + 1), 32'(n_valid));
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: verification/tb_clock_gen.sv
// Free-running clock for the SDRAM controller testbench, 20 ns period
module tb_clock_gen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

// File: vlog.f
rtl/sdram_pkg.sv
rtl/sdram_ctrl_if.sv
rtl/sdram_fsm.sv
rtl/refresh_timer.sv
rtl/sdram_cmd_gen.sv
rtl/sdram_data_path.sv
rtl/sdram_controller.sv
verification/tb_clock_gen.sv
verification/sdram_controller_asserts.sv
verification/sdram_controller_tb.sv
